/* common/emu_token_pkg.sv */
`default_nettype none

package emu_token_pkg;

    // ====================
    // Token channel bundles
    // ====================

    // Driven by the scheduler toward the backend.
    typedef struct packed {
        logic req_valid;                        // Request token offered.
        logic resp_ready;                       // Response token accepted.
    } tok_ctrl_t;

    // Driven by the backend toward the scheduler.
    typedef struct packed {
        logic req_ready;                        // Backend can take a request token.
        logic resp_valid;                       // Backend offers a response token.
    } tok_stat_t;

    // A channel fires when its valid and ready meet in the same host cycle.
    // The scheduler holds one done flag per channel until the next tick,
    // so each channel fires at most once per target cycle.

endpackage : emu_token_pkg

`default_nettype wire

/* common/emu_mem_pkg.sv */
`default_nettype none

package emu_mem_pkg;

    // ====================
    // Geometry
    // ====================

    localparam int EMU_ADDR_W = 6;              // 64 words.
    localparam int EMU_DATA_W = 32;

    // ====================
    // Target operations
    // ====================

    typedef enum logic [1:0] {
        MEM_NOP   = 2'd0,                       // Idle target cycle.
        MEM_READ  = 2'd1,
        MEM_WRITE = 2'd2
    } mem_op_e;

    // Request the target issues in one target cycle, 40 bits.
    typedef struct packed {
        mem_op_e                 op;
        logic [EMU_ADDR_W-1:0]   addr;
        logic [EMU_DATA_W-1:0]   wdata;
    } mem_req_t;

    // Read answer, valid only for a read, 33 bits.
    typedef struct packed {
        logic                    valid;
        logic [EMU_DATA_W-1:0]   rdata;
    } mem_rsp_t;

    // ====================
    // Backend FSM
    // ====================

    typedef enum logic [1:0] {
        BE_IDLE = 2'd0,                         // Waiting for a request token.
        BE_BUSY = 2'd1,                         // Modelling host latency.
        BE_RESP = 2'd2                          // Offering the response token.
    } be_state_e;

endpackage : emu_mem_pkg

`default_nettype wire

/* token_sched/token_sched.sv */
`default_nettype none

// Target-time barrier. Target time advances only after every token
// channel has fired once in the current target cycle.
module token_sched import emu_token_pkg::*; (
    input  wire logic      host_clk,
    input  wire logic      tk_rst_fire,
    input  wire logic      run_mode,
    input  wire tok_stat_t tok_stat,
    output tok_ctrl_t      tok_ctrl,
    output logic           tick
);

    // ====================
    // Request channel
    // ====================

    logic req_done;                             // Request token already taken.
    logic req_fire;

    assign tok_ctrl.req_valid = run_mode && !req_done;
    assign req_fire           = tok_ctrl.req_valid && tok_stat.req_ready;

    always_ff @(posedge host_clk) begin
        if (tk_rst_fire || tick) begin
            req_done <= 1'b0;                   // New target cycle.
        end else if (req_fire) begin
            req_done <= 1'b1;
        end
    end

    // ====================
    // Response channel
    // ====================

    logic resp_done;                            // Response token already taken.
    logic resp_fire;

    assign tok_ctrl.resp_ready = run_mode && !resp_done;
    assign resp_fire           = tok_ctrl.resp_ready && tok_stat.resp_valid;

    always_ff @(posedge host_clk) begin
        if (tk_rst_fire || tick) begin
            resp_done <= 1'b0;
        end else if (resp_fire) begin
            resp_done <= 1'b1;
        end
    end

    // ====================
    // Tick
    // ====================

    // A channel counts as finished when it fires now or fired earlier in
    // this target cycle. Flags survive a run_mode drop, so a stalled
    // target cycle resumes where it stopped.
    logic [1:0] chan_fin;

    assign chan_fin = {
        resp_fire || resp_done,
        req_fire  || req_done
    };

    assign tick = run_mode && (&chan_fin);    // One-cycle pulse, flags clear next edge.

endmodule : token_sched

`default_nettype wire

/* emu_ram/emu_ram_target.sv */
`default_nettype none

// Target-visible edge of the RAM. Both registers move only on tick, so
// what the target sees never depends on host-side latency.
module emu_ram_target import emu_mem_pkg::*; (
    input  wire logic     host_clk,
    input  wire logic     tk_rst_fire,
    input  wire logic     tick,
    input  wire mem_req_t tgt_req,
    output mem_rsp_t      tgt_rsp,
    output mem_req_t      cur_req,
    input  wire mem_rsp_t be_rsp
);

    // ====================
    // Control fields
    // ====================

    always_ff @(posedge host_clk) begin
        if (tk_rst_fire) begin
            cur_req.op    <= MEM_NOP;           // No access before first tick.
            tgt_rsp.valid <= 1'b0;
        end else if (tick) begin
            cur_req.op    <= tgt_req.op;        // Request for the next target cycle.
            tgt_rsp.valid <= be_rsp.valid;      // Answer to the previous request.
        end
    end

    // ====================
    // Payload fields
    // ====================

    always_ff @(posedge host_clk) begin
        if (tick) begin
            cur_req.addr  <= tgt_req.addr;
            cur_req.wdata <= tgt_req.wdata;
            tgt_rsp.rdata <= be_rsp.rdata;
        end
    end

    // A request captured at tick k reaches the backend through cur_req
    // during target cycle k+1. Its answer is taken from be_rsp at tick
    // k+1 and stays on tgt_rsp for the whole following target cycle.

endmodule : emu_ram_target

`default_nettype wire

/* emu_ram/emu_ram_backend.sv */
`default_nettype none

// Host-side model of the RAM. Serves one request token per target
// cycle and spends MEM_LATENCY host cycles on it before answering.
module emu_ram_backend
    import emu_mem_pkg::*;
    import emu_token_pkg::*;
#(
    parameter int unsigned MEM_LATENCY = 3
)(
    input  wire logic      host_clk,
    input  wire logic      tk_rst_fire,
    input  wire tok_ctrl_t tok_ctrl,
    output tok_stat_t      tok_stat,
    input  wire mem_req_t  cur_req,
    output mem_rsp_t       be_rsp
);

    localparam int MEM_DEPTH = 1 << EMU_ADDR_W;
    localparam int CNT_W     = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(MEM_LATENCY - 1);

    // ====================
    // Token handshakes
    // ====================

    be_state_e state;
    logic      req_fire;
    logic      resp_fire;

    assign tok_stat.req_ready  = (state == BE_IDLE);
    assign tok_stat.resp_valid = (state == BE_RESP);

    assign req_fire  = tok_ctrl.req_valid  && tok_stat.req_ready;
    assign resp_fire = tok_ctrl.resp_ready && tok_stat.resp_valid;

    // ====================
    // Storage
    // ====================

    logic [EMU_DATA_W-1:0] mem [MEM_DEPTH];
    logic [EMU_DATA_W-1:0] rd_data;             // Read data held until the answer.

    initial begin
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[i] = '0;                        // Power-up contents.
        end
    end

    always_ff @(posedge host_clk) begin
        if (req_fire && cur_req.op == MEM_WRITE) begin
            mem[cur_req.addr] <= cur_req.wdata; // Visible to the next target cycle.
        end
        if (req_fire && cur_req.op == MEM_READ) begin
            rd_data <= mem[cur_req.addr];
        end
    end

    // ====================
    // Latency FSM
    // ====================

    logic [CNT_W-1:0] lat_cnt;                  // Host cycles spent in BE_BUSY.
    logic             rsp_is_read;              // Current request was a read.

    always_ff @(posedge host_clk) begin
        if (tk_rst_fire) begin
            state       <= BE_IDLE;
            lat_cnt     <= '0;
            rsp_is_read <= 1'b0;
        end else begin
            case (state)
                BE_IDLE: begin
                    if (req_fire) begin
                        state       <= BE_BUSY;
                        lat_cnt     <= '0;
                        rsp_is_read <= (cur_req.op == MEM_READ);
                    end
                end
                BE_BUSY: begin
                    if (lat_cnt == CNT_LAST) begin
                        state <= BE_RESP;       // Latency used up.
                    end else begin
                        lat_cnt <= lat_cnt + 1'b1;
                    end
                end
                BE_RESP: begin
                    // Waits here while run_mode is low.
                    if (resp_fire) begin
                        state <= BE_IDLE;
                    end
                end
                default: begin
                    state <= BE_IDLE;
                end
            endcase
        end
    end

    // ====================
    // Response
    // ====================

    assign be_rsp.valid = (state == BE_RESP) && rsp_is_read;
    assign be_rsp.rdata = rd_data;              // Sampled by the target on tick.

endmodule : emu_ram_backend

`default_nettype wire

/* verilog/emu_ram_top.sv */
`default_nettype none

// Emulation RAM: token scheduler, target front end and host backend.
module emu_ram_top
    import emu_mem_pkg::*;
    import emu_token_pkg::*;
#(
    parameter int unsigned MEM_LATENCY = 3
)(
    input  wire logic     host_clk,
    input  wire logic     tk_rst_fire,
    input  wire logic     run_mode,
    input  wire mem_req_t tgt_req,
    output mem_rsp_t      tgt_rsp,
    output logic          tick
);

    // ====================
    // Internal links
    // ====================

    tok_ctrl_t tok_ctrl;                        // Scheduler to backend.
    tok_stat_t tok_stat;                        // Backend to scheduler.
    mem_req_t  cur_req;                         // Request of this target cycle.
    mem_rsp_t  be_rsp;                          // Answer waiting for tick.

    // ====================
    // Instances
    // ====================

    token_sched token_sched_inst (
        .host_clk    (host_clk),
        .tk_rst_fire (tk_rst_fire),
        .run_mode    (run_mode),
        .tok_stat    (tok_stat),
        .tok_ctrl    (tok_ctrl),
        .tick        (tick)
    );

    emu_ram_target emu_ram_target_inst (
        .host_clk    (host_clk),
        .tk_rst_fire (tk_rst_fire),
        .tick        (tick),
        .tgt_req     (tgt_req),
        .tgt_rsp     (tgt_rsp),
        .cur_req     (cur_req),
        .be_rsp      (be_rsp)
    );

    emu_ram_backend #(
        .MEM_LATENCY (MEM_LATENCY)
    ) emu_ram_backend_inst (
        .host_clk    (host_clk),
        .tk_rst_fire (tk_rst_fire),
        .tok_ctrl    (tok_ctrl),
        .tok_stat    (tok_stat),
        .cur_req     (cur_req),
        .be_rsp      (be_rsp)
    );

endmodule : emu_ram_top

`default_nettype wire

/* verif/emu_ram_assert.sv */
`default_nettype none

// Token and tick rules of the scheduler.
module emu_ram_assert import emu_token_pkg::*; (
    input wire logic      host_clk,
    input wire logic      tk_rst_fire,
    input wire logic      run_mode,
    input wire tok_ctrl_t tok_ctrl,
    input wire tok_stat_t tok_stat,
    input wire logic      tick
);

    timeunit 1ns;
    timeprecision 1ps;

    int   assert_errors = 0;                    // Failures seen so far.
    logic req_fire;
    logic resp_fire;
    logic req_seen;                             // Fired since the last tick.
    logic resp_seen;

    assign req_fire  = tok_ctrl.req_valid && tok_stat.req_ready;
    assign resp_fire = tok_ctrl.resp_ready && tok_stat.resp_valid;

    always_ff @(posedge host_clk) begin
        if (tk_rst_fire || tick) begin
            req_seen  <= 1'b0;
            resp_seen <= 1'b0;
        end else begin
            if (req_fire) begin
                req_seen <= 1'b1;
            end
            if (resp_fire) begin
                resp_seen <= 1'b1;
            end
        end
    end

    // ====================
    // Properties
    // ====================

    // The backend answers only after the request of this target cycle,
    // so a tick always lands on the cycle the response is offered.
    tick_needs_run: assert property (@(posedge host_clk) disable iff (tk_rst_fire)
        tick |-> run_mode && tok_stat.resp_valid)
        else begin
            assert_errors++;
            $error("tick high without run_mode or without a response offer");
        end

    req_once: assert property (@(posedge host_clk) disable iff (tk_rst_fire)
        req_fire |-> !req_seen)
        else begin
            assert_errors++;
            $error("request token fired twice in one target cycle");
        end

    resp_once: assert property (@(posedge host_clk) disable iff (tk_rst_fire)
        resp_fire |-> !resp_seen)
        else begin
            assert_errors++;
            $error("response token fired twice in one target cycle");
        end

    tick_pulse: assert property (@(posedge host_clk) disable iff (tk_rst_fire)
        tick |=> !tick)
        else begin
            assert_errors++;
            $error("tick lasted more than one host cycle");
        end

endmodule : emu_ram_assert

bind token_sched emu_ram_assert emu_ram_assert_inst (
    .host_clk    (host_clk),
    .tk_rst_fire (tk_rst_fire),
    .run_mode    (run_mode),
    .tok_ctrl    (tok_ctrl),
    .tok_stat    (tok_stat),
    .tick        (tick)
);

`default_nettype wire

/* verif/emu_ram_tb.sv */
`default_nettype none

module emu_ram_tb import emu_mem_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // ====================
    // Run parameters
    // ====================

    localparam int unsigned MEM_LATENCY  = 3;
    localparam int          CLK_PERIOD   = 100;
    localparam int          RST_CYCLES   = 4;
    localparam int          IDLE_CYCLES  = 20;   // run_mode low after reset.
    localparam int          PERIOD_TICKS = 8;
    localparam int          RUN_CYCLES   = 200;  // Random target cycles per run.
    localparam int          FRAME_CYCLES = 40;
    localparam int          MEM_WORDS    = 1 << EMU_ADDR_W;
    localparam logic [31:0] SEED         = 32'h5f7fbd90;

    // Every random run adds two flush target cycles at its end.
    localparam int TOTAL_TCYC  = 1 + PERIOD_TICKS + 2 * (RUN_CYCLES + 2) + (FRAME_CYCLES + 2);
    localparam int CYCLE_LIMIT = 2 * TOTAL_TCYC * (MEM_LATENCY + 2) + 200;

    logic     host_clk;
    logic     tk_rst_fire;
    logic     run_mode;
    mem_req_t tgt_req;
    mem_rsp_t tgt_rsp;
    logic     tick;

    // ====================
    // Model state
    // ====================

    logic [EMU_DATA_W-1:0] model_mem [MEM_WORDS];
    mem_req_t              pending_q [$];       // Request waiting for its answer.
    mem_req_t              drv_req;             // Copy of what is on tgt_req.
    logic                  ref_valid [RUN_CYCLES + 2];
    logic [31:0]           req_state;
    logic [31:0]           stall_state;
    logic [EMU_ADDR_W-1:0] last_addr;
    int                    cycle_count  = 0;
    int                    error_count  = 0;
    int                    check_count  = 0;
    int                    tests_run    = 0;
    int                    tests_failed = 0;

    emu_ram_top #(
        .MEM_LATENCY (MEM_LATENCY)
    ) emu_ram_top_inst (
        .host_clk    (host_clk),
        .tk_rst_fire (tk_rst_fire),
        .run_mode    (run_mode),
        .tgt_req     (tgt_req),
        .tgt_rsp     (tgt_rsp),
        .tick        (tick)
    );

    initial begin
        host_clk = 1'b0;
        forever #(CLK_PERIOD / 2) host_clk = ~host_clk;
    end

    always @(posedge host_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: target time stopped after %0d host cycles", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    // ====================
    // Helpers
    // ====================

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error: %s got 0x%0h expected 0x%0h at cycle %0d",
                     name, got, exp, cycle_count);
        end
    endtask

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_next(state);
            val   = {val[30:0], state[0]};      // One step per bit.
        end
    endtask

    task automatic draw_request(output mem_req_t r);
        logic [31:0] v;
        logic        reuse;
        draw_bits(req_state, 2, v);
        case (v[1:0])
            2'd0:    r.op = MEM_NOP;
            2'd2:    r.op = MEM_WRITE;
            default: r.op = MEM_READ;
        endcase
        draw_bits(req_state, 2, v);
        reuse = (v[1:0] == 2'b11);             // Hit the previous address now and then.
        draw_bits(req_state, EMU_ADDR_W, v);
        if (!reuse) begin
            last_addr = v[EMU_ADDR_W-1:0];
        end
        r.addr = last_addr;
        draw_bits(req_state, EMU_DATA_W, v);
        r.wdata = v;
    endtask

    task automatic drive_stall();
        logic [31:0] v;
        draw_bits(stall_state, 2, v);
        run_mode <= (v[1:0] != 2'b00);          // Low about one cycle in four.
    endtask

    task automatic hold_reset();
        for (int i = 0; i < RST_CYCLES; i++) begin
            @(posedge host_clk);
            if (i == RST_CYCLES - 1) begin
                tk_rst_fire <= 1'b0;
            end
            @(negedge host_clk);
            check_value("tick", 64'(tick), 64'(0));
            check_value("tgt_rsp.valid", 64'(tgt_rsp.valid), 64'(0));
        end
    endtask

    // Returns with the clock at a falling edge where tick is high.
    task automatic wait_next_tick(input bit stall, output int waited);
        waited = 0;
        do begin
            @(posedge host_clk);
            if (stall) begin
                drive_stall();
            end
            @(negedge host_clk);
            waited++;
            if (!run_mode) begin
                check_value("tick (run_mode low)", 64'(tick), 64'(0));
            end
        end while (!tick);
    endtask

    task automatic check_response(input mem_req_t req, input int idx,
                                  input bit record, input bit compare);
        logic                  exp_valid;
        logic [EMU_DATA_W-1:0] exp_data;
        exp_valid = (req.op == MEM_READ);
        exp_data  = model_mem[req.addr];
        if (req.op == MEM_WRITE) begin
            model_mem[req.addr] = req.wdata;    // Seen by the next target cycle.
        end
        check_value("tgt_rsp.valid", 64'(tgt_rsp.valid), 64'(exp_valid));
        if (exp_valid) begin
            check_value("tgt_rsp.rdata", 64'(tgt_rsp.rdata), 64'(exp_data));
        end
        if (record) begin
            ref_valid[idx] = exp_valid;
        end
        if (compare) begin
            check_value("tgt_rsp.valid (unstalled run)", 64'(tgt_rsp.valid),
                        64'(ref_valid[idx]));
        end
    endtask

    // Starts and ends at a tick. The last two requests are NOPs, which
    // lets every random request be answered inside the run.
    task automatic run_target_cycles(input int count, input bit stall,
                                     input bit record, input bit compare);
        mem_req_t answered;
        mem_req_t next_req;
        int       waited;
        for (int i = 0; i <= count + 1; i++) begin
            answered = pending_q.pop_front();
            pending_q.push_back(drv_req);       // Captured by this tick.
            @(posedge host_clk);
            if (i < count) begin
                draw_request(next_req);
            end else begin
                next_req = '0;
            end
            tgt_req <= next_req;
            drv_req = next_req;
            if (stall) begin
                drive_stall();
            end
            @(negedge host_clk);
            check_response(answered, i, record, compare);
            wait_next_tick(stall, waited);
        end
    endtask

    task automatic end_test(input int num, input string name, input int errs_at_start);
        int errs;
        errs = error_count - errs_at_start;
        tests_run++;
        if (errs == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL with %0d errors", num, name, errs);
        end
    endtask

    // ====================
    // Test sequence
    // ====================

    initial begin
        int errs;
        int waited;
        tk_rst_fire = 1'b1;
        run_mode    = 1'b0;
        tgt_req     = '0;
        drv_req     = '0;
        req_state   = SEED;
        stall_state = SEED;
        last_addr   = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end

        errs = error_count;
        hold_reset();
        repeat (IDLE_CYCLES) begin
            @(negedge host_clk);
            check_value("tick", 64'(tick), 64'(0));
            check_value("tgt_rsp.valid", 64'(tgt_rsp.valid), 64'(0));
        end
        end_test(1, "reset state", errs);

        errs = error_count;
        @(posedge host_clk);
        tk_rst_fire <= 1'b1;
        run_mode    <= 1'b1;
        hold_reset();
        wait_next_tick(1'b0, waited);
        check_value("first tick delay", 64'(waited + 1), 64'(MEM_LATENCY + 2));
        repeat (PERIOD_TICKS) begin
            wait_next_tick(1'b0, waited);
            check_value("tick spacing", 64'(waited), 64'(MEM_LATENCY + 2));
        end
        end_test(2, "tick period", errs);

        errs = error_count;
        req_state = SEED;
        last_addr = '0;
        pending_q.push_back(drv_req);           // NOP from the last tick.
        run_target_cycles(RUN_CYCLES, 1'b0, 1'b1, 1'b0);
        end_test(3, "read-after-write data", errs);

        errs = error_count;
        run_target_cycles(FRAME_CYCLES, 1'b0, 1'b0, 1'b0);
        end_test(4, "response framing", errs);

        errs = error_count;
        stall_state = req_state;
        req_state   = SEED;                     // Same requests as test 3.
        last_addr   = '0;
        run_target_cycles(RUN_CYCLES, 1'b1, 1'b0, 1'b1);
        check_value("assertion failures",
                    64'(emu_ram_top_inst.token_sched_inst.emu_ram_assert_inst.assert_errors),
                    64'(0));
        end_test(5, "stall independence", errs);

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule : emu_ram_tb

`default_nettype wire

/* emu_ram.f */
common/emu_token_pkg.sv
common/emu_mem_pkg.sv
token_sched/token_sched.sv
emu_ram/emu_ram_target.sv
emu_ram/emu_ram_backend.sv
verilog/emu_ram_top.sv
verif/emu_ram_assert.sv
verif/emu_ram_tb.sv

/* Makefile */
# Verilator build and run of the emulation RAM testbench.

VERILATOR ?= verilator
TOP       ?= emu_ram_tb
FILELIST  ?= emu_ram.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# The run passes only if the log holds the pass line.
sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
